//--- dv/elink_tb.sv
// loopback testbench; words matched in order, latency not checked, one 16-bit LFSR
`timescale 1ns/1ps
`default_nettype none
`include "elink_config.svh"

module elink_tb
  import elink_pkg::*;
();

  logic       bit_clk;
  logic       arst_n;
  logic [9:0] edata_in;
  logic       data_rdy;
  logic       swap_outbits;
  logic       get_data_trig;
  logic [1:0] lane;
  logic [7:0] rx_data;
  logic       rx_k;
  logic       rx_valid;
  logic       rx_locked;
  logic       code_err;
  logic       disp_err;

  elink_sym_t  exp_q[$];   // expected characters, oldest first
  elink_sym_t  exp_head;
  logic [15:0] lfsr_state;
  int          value_errs;
  int          other_errs;
  int          n_checked;
  bit          run_ok;

  elink_loopback_top elink_loopback_top_i (
    .bit_clk       (bit_clk),
    .arst_n        (arst_n),
    .edata_in      (edata_in),
    .data_rdy      (data_rdy),
    .swap_outbits  (swap_outbits),
    .get_data_trig (get_data_trig),
    .lane          (lane),
    .rx_data       (rx_data),
    .rx_k          (rx_k),
    .rx_valid      (rx_valid),
    .rx_locked     (rx_locked),
    .code_err      (code_err),
    .disp_err      (disp_err)
  );

  initial bit_clk = 1'b0;
  always #4 bit_clk = ~bit_clk; // 8 ns period

  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // one LFSR step per bit
  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[6:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // what the receiver should show for a word
  function automatic elink_sym_t expected_char(input elink_code_t code, input logic [7:0] payload);
    elink_sym_t e;
    case (code)
      CODE_DATA: e = '{k: 1'b0, data: payload}; // byte passes untouched
      CODE_SOP:  e = '{k: 1'b1, data: 8'h3C};   // K28.1
      CODE_EOP:  e = '{k: 1'b1, data: 8'hDC};   // K28.6
      default:   e = '{k: 1'b1, data: 8'hBC};   // K28.5, masked at rx
    endcase
    return e;
  endfunction

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp) else begin
      $display("** Error at %0d ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  // quiet state, used in and right after reset
  task automatic check_quiet_outputs();
    check_value("get_data_trig", {7'b0, get_data_trig}, 8'h00);
    check_value("rx_valid", {7'b0, rx_valid}, 8'h00);
    check_value("rx_locked", {7'b0, rx_locked}, 8'h00);
    check_value("code_err", {7'b0, code_err}, 8'h00);
    check_value("disp_err", {7'b0, disp_err}, 8'h00);
  endtask

  // lane right out of reset carries the RD- comma, 'a' first
  task automatic check_reset_comma(input bit swap);
    logic [9:0] abc;  // abcdei fghj
    logic [9:0] exp;
    logic [9:0] got;
    abc = 10'b001111_1010; // K28.5, RD-
    got = '0;
    for (int i = 0; i < 10; i++) begin
      exp[i] = abc[9-i];
    end
    for (int k = 0; k < `ELINK_SYM_CYCLES; k++) begin
      if (k != 0) begin
        @(posedge bit_clk);
        #1;
      end
      got[2*k]   = swap ? lane[1] : lane[0]; // pair bits exchanged on the wire
      got[2*k+1] = swap ? lane[0] : lane[1];
    end
    assert (got === exp) else begin
      $display("** Error at %0d ns: lane = 0x%h, expected 0x%h", $time, got, exp);
      value_errs++;
    end
  endtask

  // leaves us in the request cycle, 1 ns past the edge
  task automatic wait_request(output bit ok);
    int n;
    n = 0;
    while (!get_data_trig && n < 3 * `ELINK_SYM_CYCLES) begin
      @(posedge bit_clk);
      #1;
      n++;
    end
    ok = get_data_trig;
  endtask

  task automatic wait_lock(output bit ok);
    int n;
    n = 0;
    while (!rx_locked && n < 20 * `ELINK_SYM_CYCLES) begin // idles only meanwhile
      @(posedge bit_clk);
      #1;
      n++;
    end
    ok = rx_locked;
  endtask

  task automatic wait_drain(output bit ok);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 40 * `ELINK_SYM_CYCLES) begin
      @(posedge bit_clk);
      #1;
      n++;
    end
    ok = (exp_q.size() == 0);
  endtask

  // data_rdy for one cycle in window slot 0..3
  task automatic offer_word(input logic [1:0] slot, input logic [9:0] word);
    repeat (int'(slot) + 1) begin
      @(posedge bit_clk);
      #1;
    end
    check_value("get_data_trig", {7'b0, get_data_trig}, 8'h00); // pulse is one cycle wide
    edata_in = word;
    data_rdy = 1'b1;
    @(posedge bit_clk);
    #1;
    data_rdy = 1'b0;
  endtask

  // reset, lock, n_req requests, drain
  task automatic run_phase(input bit swap, input int n_req, output bit ok);
    logic [7:0]  bits;
    logic [7:0]  payload;
    logic [1:0]  slot;
    elink_code_t code;
    elink_sym_t  e;
    bit          answer;
    arst_n       = 1'b0;
    data_rdy     = 1'b0;
    swap_outbits = swap;
    @(negedge bit_clk);
    check_quiet_outputs();
    @(posedge bit_clk);
    @(posedge bit_clk);
    #1;
    arst_n = 1'b1; // held for 2 edges
    check_quiet_outputs();
    check_reset_comma(swap);
    wait_lock(ok);
    if (!ok) begin
      $display("Error: receiver did not lock on idle commas (swap %0b)", swap);
      other_errs++;
    end
    for (int i = 0; i < n_req && ok; i++) begin
      wait_request(ok);
      if (!ok) begin
        $display("Error: no get_data_trig pulse at %0d ns", $time);
        other_errs++;
      end else begin
        take_bits(2, bits);
        answer = (bits[1:0] != 2'b00) && !(i >= n_req / 2 && i < n_req / 2 + 16); // idle stretch
        if (answer) begin
          take_bits(8, payload);
          take_bits(3, bits);
          if (bits[2:0] < 3'd5) code = CODE_DATA; // mostly payload
          else if (bits[2:0] == 3'd5) code = CODE_SOP;
          else if (bits[2:0] == 3'd6) code = CODE_EOP;
          else code = CODE_IDLE;
          take_bits(2, bits);
          slot = bits[1:0];
          e    = expected_char(code, payload);
          if (!(e.k && e.data == 8'hBC)) exp_q.push_back(e); // idles never show up
          offer_word(slot, {code, payload});
        end else begin
          @(posedge bit_clk); // move past this request
          #1;
        end
      end
    end
    if (ok) begin
      wait_drain(ok);
      if (!ok) begin
        $display("Error: %0d expected symbols never arrived (swap %0b)", exp_q.size(), swap);
        other_errs++;
      end
    end
  endtask

  // scoreboard, sampled mid-cycle
  always @(negedge bit_clk) begin
    check_value("code_err", {7'b0, code_err}, 8'h00);
    check_value("disp_err", {7'b0, disp_err}, 8'h00);
    if (rx_valid) begin
      if (exp_q.size() == 0) begin
        $display("Error: symbol 0x%h received at %0d ns with none expected", rx_data, $time);
        other_errs++;
      end else begin
        exp_head = exp_q.pop_front();
        check_value("rx_k", {7'b0, rx_k}, {7'b0, exp_head.k});
        check_value("rx_data", rx_data, exp_head.data);
        n_checked++;
      end
    end
  end

  initial begin
    arst_n       = 1'b0;
    edata_in     = '0;
    data_rdy     = 1'b0;
    swap_outbits = 1'b0;
    lfsr_state   = 16'd23732;
    value_errs   = 0;
    other_errs   = 0;
    n_checked    = 0;
    @(posedge bit_clk);
    #1;
    run_phase(1'b0, 200, run_ok);
    if (run_ok) run_phase(1'b1, 200, run_ok); // second reset, swapped lane
    $display("errors: %0d value, %0d other; %0d symbols checked",
             value_errs, other_errs, n_checked);
    if (value_errs == 0 && other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/dec_8b10b.sv
// 8b10b decoder; K detection covers K28.y only, disparity is checked from the second strobe on
`timescale 1ns/1ps
`default_nettype none
`include "elink_config.svh"

module dec_8b10b
  import elink_pkg::*;
(
  input  wire                        bit_clk,
  input  wire                        arst_n,
  input  wire [`ELINK_SYM_BITS-1:0]  sym10,   // lane order, bit 0 = 'a'
  input  wire                        strobe,
  elink_sym_if.dec                   sif
);

  logic       rd;       // 0 = RD-
  logic       rd_known; // no reference before the first symbol
  logic [9:0] code;     // abcdei fghj
  logic [5:0] six;
  logic [3:0] four;
  logic [3:0] four_l;   // K code folded back to data form
  logic [5:0] c6;
  logic [3:0] c4;
  logic [3:0] pop6;
  logic [2:0] pop4;
  logic       is_k;
  logic [4:0] x;
  logic [2:0] y;
  logic       x_ok;
  logic       y_ok;
  logic       unbal6;
  logic       unbal4;
  logic       rd_mid;
  logic       rd_next;
  logic       code_bad;
  logic       disp_bad;

  always_comb begin
    for (int i = 0; i < `ELINK_SYM_BITS; i++) begin
      code[`ELINK_SYM_BITS-1-i] = sym10[i];
    end
    six  = code[9:4];
    four = code[3:0];
    pop6 = 4'($countones(six));
    pop4 = 3'($countones(four));
    is_k = (six == 6'b001111) || (six == 6'b110000);

    // 6b reverse lookup, complements only where the encoder makes them
    x    = 5'd28;
    x_ok = is_k;
    for (int i = 0; i < 32; i++) begin
      c6 = enc6_rdn(5'(i));
      if (six == c6 || (($countones(c6) != 3 || i == 7) && six == ~c6)) begin
        x    = 5'(i);
        x_ok = 1'b1;
      end
    end

    unbal6 = (pop6 != 4'd3);
    rd_mid = unbal6 ? (pop6 > 4'd3) : rd;

    // 4b reverse lookup
    four_l = (is_k && six == 6'b110000 && pop4 == 3'd2) ? ~four : four;
    y      = 3'd0;
    y_ok   = 1'b0;
    for (int j = 0; j < 8; j++) begin
      c4 = enc4_rdn(3'(j));
      if (four_l == c4 || (($countones(c4) != 2 || j == 3) && four_l == ~c4)) begin
        y    = 3'(j);
        y_ok = 1'b1;
      end
    end
    if (four_l == 4'b0111 || four_l == 4'b1000) begin // A7
      y    = 3'd7;
      y_ok = 1'b1;
    end

    unbal4  = (pop4 != 3'd2);
    rd_next = unbal4 ? (pop4 > 3'd2) : rd_mid;

    code_bad = !x_ok || !y_ok;
    // an unbalanced block must point away from the current disparity
    disp_bad = rd_known && ((unbal6 && ((pop6 > 4'd3) == rd)) ||
                            (unbal4 && ((pop4 > 3'd2) == rd_mid)));
  end

  always_ff @(posedge bit_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd           <= 1'b0;
      rd_known     <= 1'b0;
      sif.valid    <= 1'b0;
      sif.code_err <= 1'b0;
      sif.disp_err <= 1'b0;
    end else begin
      sif.valid    <= strobe;
      sif.code_err <= strobe && code_bad;
      sif.disp_err <= strobe && disp_bad;
      if (strobe) begin
        rd       <= rd_next;
        rd_known <= 1'b1;
      end
    end
  end

  // payload, qualified by valid
  always_ff @(posedge bit_clk) begin
    if (strobe) begin
      sif.sym <= '{k: is_k, data: {y, x}};
    end
  end

endmodule

`default_nettype wire

//--- rtl/elink_config.svh
// elink constants; lane bit order is lsb first, so the comma value is the lane-order bit pattern
`ifndef ELINK_CONFIG_SVH
`define ELINK_CONFIG_SVH

// symbol and lane geometry
`define ELINK_SYM_BITS   10
`define ELINK_LANE_BITS  2
`define ELINK_SYM_CYCLES 5 // bit_clk cycles per 10b symbol

// K28.5 for RD-, bit 0 is 'a' and goes out first
`define ELINK_K28_5_RDN  10'h17C

// commas at one offset before lock
`define ELINK_ALIGN_HITS 2

// control characters
`define ELINK_SOP_BYTE   8'h3C // K28.1
`define ELINK_EOP_BYTE   8'hDC // K28.6
`define ELINK_IDLE_BYTE  8'hBC // K28.5

`endif

//--- rtl/elink_loopback_top.sv
// tx and rx joined over one 2-bit lane, both ends on bit_clk; swap_outbits applies to both
`timescale 1ns/1ps
`default_nettype none
`include "elink_config.svh"

module elink_loopback_top (
  input  wire                         bit_clk,
  input  wire                         arst_n,
  input  wire [9:0]                   edata_in,      // code in [9:8]
  input  wire                         data_rdy,
  input  wire                         swap_outbits,
  output logic                        get_data_trig,
  output logic [`ELINK_LANE_BITS-1:0] lane,          // for observation
  output logic [7:0]                  rx_data,
  output logic                        rx_k,
  output logic                        rx_valid,
  output logic                        rx_locked,
  output logic                        code_err,
  output logic                        disp_err
);

  elink_tx elink_tx_i (
    .bit_clk       (bit_clk),
    .arst_n        (arst_n),
    .edata_in      (edata_in),
    .data_rdy      (data_rdy),
    .swap_outbits  (swap_outbits),
    .get_data_trig (get_data_trig),
    .lane          (lane)
  );

  // rx samples the same wires the tx drives
  elink_rx elink_rx_i (
    .bit_clk      (bit_clk),
    .arst_n       (arst_n),
    .lane         (lane),
    .swap_outbits (swap_outbits),
    .rx_data      (rx_data),
    .rx_k         (rx_k),
    .rx_valid     (rx_valid),
    .rx_locked    (rx_locked),
    .code_err     (code_err),
    .disp_err     (disp_err)
  );

endmodule

`default_nettype wire

//--- rtl/elink_pkg.sv
// shared types and 8b10b sub-block tables; tables give the RD- column in abcdei / fghj order
`default_nettype none

package elink_pkg;

  // 2-bit code field on top of edata_in
  typedef enum logic [1:0] {
    CODE_DATA = 2'b00, // payload byte
    CODE_SOP  = 2'b01, // K28.1
    CODE_EOP  = 2'b10, // K28.6
    CODE_IDLE = 2'b11  // K28.5
  } elink_code_t;

  // unencoded character
  typedef struct packed {
    logic       k;
    logic [7:0] data;
  } elink_sym_t;

  // 5b6b, RD- column, bit 5 is 'a'
  function automatic logic [5:0] enc6_rdn(input logic [4:0] x);
    logic [5:0] t;
    case (x)
      5'd0:  t = 6'b100111;
      5'd1:  t = 6'b011101;
      5'd2:  t = 6'b101101;
      5'd3:  t = 6'b110001;
      5'd4:  t = 6'b110101;
      5'd5:  t = 6'b101001;
      5'd6:  t = 6'b011001;
      5'd7:  t = 6'b111000; // balanced but still flips
      5'd8:  t = 6'b111001;
      5'd9:  t = 6'b100101;
      5'd10: t = 6'b010101;
      5'd11: t = 6'b110100;
      5'd12: t = 6'b001101;
      5'd13: t = 6'b101100;
      5'd14: t = 6'b011100;
      5'd15: t = 6'b010111;
      5'd16: t = 6'b011011;
      5'd17: t = 6'b100011;
      5'd18: t = 6'b010011;
      5'd19: t = 6'b110010;
      5'd20: t = 6'b001011;
      5'd21: t = 6'b101010;
      5'd22: t = 6'b011010;
      5'd23: t = 6'b111010;
      5'd24: t = 6'b110011;
      5'd25: t = 6'b100110;
      5'd26: t = 6'b010110;
      5'd27: t = 6'b110110;
      5'd28: t = 6'b001110;
      5'd29: t = 6'b101110;
      5'd30: t = 6'b011110;
      default: t = 6'b101011;
    endcase
    return t;
  endfunction

  // 3b4b, primary codes for RD- after the 6b block, bit 3 is 'f'
  function automatic logic [3:0] enc4_rdn(input logic [2:0] y);
    logic [3:0] t;
    case (y)
      3'd0: t = 4'b1011;
      3'd1: t = 4'b1001;
      3'd2: t = 4'b0101;
      3'd3: t = 4'b1100; // balanced, flips like D.07
      3'd4: t = 4'b1101;
      3'd5: t = 4'b1010;
      3'd6: t = 4'b0110;
      default: t = 4'b1110; // P7, A7 handled by caller
    endcase
    return t;
  endfunction

endpackage

`default_nettype wire

//--- rtl/elink_rx.sv
// e-link receiver; lock is sticky until reset, idles are decoded but not reported
`timescale 1ns/1ps
`default_nettype none
`include "elink_config.svh"

module elink_rx (
  input  wire                        bit_clk,
  input  wire                        arst_n,
  input  wire [`ELINK_LANE_BITS-1:0] lane,
  input  wire                        swap_outbits,
  output logic [7:0]                 rx_data,
  output logic                       rx_k,
  output logic                       rx_valid,
  output logic                       rx_locked,
  output logic                       code_err,
  output logic                       disp_err
);

  logic [`ELINK_LANE_BITS-1:0] pair_in;
  logic [11:0]                 hist;    // newest pair at the top
  logic [2:0]                  cnt;
  logic [2:0]                  cnt_nxt;
  logic [2:0]                  phase;   // strobe position within the period
  logic [2:0]                  hits;
  logic                        locked;
  logic                        comma_now;
  logic                        strobe;

  elink_sym_if sym_if ();

  assign pair_in   = swap_outbits ? {lane[0], lane[1]} : lane; // undo tx swap
  assign cnt_nxt   = (cnt == 3'(`ELINK_SYM_CYCLES - 1)) ? '0 : cnt + 3'd1;
  // window ending this cycle, either polarity
  assign comma_now = (hist[11:2] == `ELINK_K28_5_RDN) || (hist[11:2] == ~`ELINK_K28_5_RDN);
  // one cycle later that window sits in the low 10 bits
  assign strobe    = locked && (cnt == phase);

  always_ff @(posedge bit_clk or negedge arst_n) begin
    if (!arst_n) begin
      hist   <= '0;
      cnt    <= '0;
      phase  <= '0;
      hits   <= '0;
      locked <= 1'b0;
    end else begin
      hist <= {pair_in, hist[11:2]};
      cnt  <= cnt_nxt;
      if (!locked && comma_now) begin
        if (hits != '0 && phase == cnt_nxt) begin
          hits <= hits + 3'd1; // same offset again
          if (hits == 3'(`ELINK_ALIGN_HITS - 1)) locked <= 1'b1;
        end else begin
          phase <= cnt_nxt; // new candidate offset
          hits  <= 3'd1;
          if (`ELINK_ALIGN_HITS == 1) locked <= 1'b1;
        end
      end
    end
  end

  dec_8b10b dec_8b10b_i (
    .bit_clk (bit_clk),
    .arst_n  (arst_n),
    .sym10   (hist[9:0]),
    .strobe  (strobe),
    .sif     (sym_if.dec)
  );

  assign rx_data   = sym_if.sym.data;
  assign rx_k      = sym_if.sym.k;
  // idle commas are dropped here
  assign rx_valid  = sym_if.valid && !(sym_if.sym.k && sym_if.sym.data == `ELINK_IDLE_BYTE);
  assign rx_locked = locked;
  assign code_err  = sym_if.code_err;
  assign disp_err  = sym_if.disp_err;

endmodule

`default_nettype wire

//--- rtl/elink_serializer.sv
// 10b to 2b shifter; load must come every ELINK_SYM_CYCLES cycles or stale pairs go out
`timescale 1ns/1ps
`default_nettype none
`include "elink_config.svh"

module elink_serializer (
  input  wire                         bit_clk,
  input  wire                         arst_n,
  input  wire                         load,
  input  wire [`ELINK_SYM_BITS-1:0]   sym10,
  input  wire                         swap_outbits,
  output logic [`ELINK_LANE_BITS-1:0] lane
);

  logic [`ELINK_SYM_BITS-1:0] shreg;

  always_ff @(posedge bit_clk or negedge arst_n) begin
    if (!arst_n) begin
      shreg <= `ELINK_K28_5_RDN; // comma out of reset
    end else if (load) begin
      shreg <= sym10;
    end else begin
      shreg <= shreg >> `ELINK_LANE_BITS; // lsb pair first
    end
  end

  // optional exchange of the two lane bits
  assign lane = swap_outbits ? {shreg[0], shreg[1]} : shreg[1:0];

endmodule

`default_nettype wire

//--- rtl/elink_sym_if.sv
// one decoded character per valid strobe, no back-pressure; flags are only meaningful with valid
`timescale 1ns/1ps
`default_nettype none

interface elink_sym_if
  import elink_pkg::*;
  ();

  elink_sym_t sym;      // decoded k flag and byte
  logic       valid;    // single-cycle strobe
  logic       code_err; // bad sub-block
  logic       disp_err; // running disparity broken

  // decoder side
  modport dec (
    output sym, valid, code_err, disp_err
  );

  // receiver side
  modport rx (
    input sym, valid, code_err, disp_err
  );

endinterface

`default_nettype wire

//--- rtl/elink_tx.sv
// e-link transmitter; a word is taken only in the 4 cycles after the request, no back-pressure
`timescale 1ns/1ps
`default_nettype none
`include "elink_config.svh"

module elink_tx
  import elink_pkg::*;
(
  input  wire                         bit_clk,
  input  wire                         arst_n,
  input  wire [9:0]                   edata_in,     // {code, byte}
  input  wire                         data_rdy,
  input  wire                         swap_outbits,
  output logic                        get_data_trig,
  output logic [`ELINK_LANE_BITS-1:0] lane
);

  logic [2:0]                 cnt;       // symbol period position
  logic                       armed;     // inside the data_rdy window
  logic                       have_word;
  logic [9:0]                 word_q;
  logic                       load;
  elink_code_t                code;
  elink_sym_t                 sym;
  logic [`ELINK_SYM_BITS-1:0] enc;

  assign load          = (cnt == 3'(`ELINK_SYM_CYCLES - 1)); // period boundary
  assign get_data_trig = load;
  assign code          = elink_code_t'(word_q[9:8]);

  always_ff @(posedge bit_clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt       <= '0;
      armed     <= 1'b0;
      have_word <= 1'b0;
    end else begin
      cnt <= load ? '0 : cnt + 3'd1;
      if (load) begin
        armed     <= 1'b1; // request just went out
        have_word <= 1'b0; // consumed by this load
      end else begin
        if (cnt == 3'(`ELINK_SYM_CYCLES - 2)) armed <= 1'b0; // window closes
        if (armed && data_rdy && !have_word) have_word <= 1'b1;
      end
    end
  end

  // first data_rdy in the window wins
  always_ff @(posedge bit_clk) begin
    if (armed && data_rdy && !have_word) begin
      word_q <= edata_in;
    end
  end

  // code to character, comma when nothing was offered
  always_comb begin
    if (!have_word) begin
      sym = '{k: 1'b1, data: `ELINK_IDLE_BYTE};
    end else begin
      case (code)
        CODE_DATA: sym = '{k: 1'b0, data: word_q[7:0]};
        CODE_SOP:  sym = '{k: 1'b1, data: `ELINK_SOP_BYTE};
        CODE_EOP:  sym = '{k: 1'b1, data: `ELINK_EOP_BYTE};
        default:   sym = '{k: 1'b1, data: `ELINK_IDLE_BYTE};
      endcase
    end
  end

  enc_8b10b enc_8b10b_i (
    .bit_clk (bit_clk),
    .arst_n  (arst_n),
    .sym     (sym),
    .load    (load),
    .enc     (enc)
  );

  elink_serializer elink_serializer_i (
    .bit_clk      (bit_clk),
    .arst_n       (arst_n),
    .load         (load),
    .sym10        (enc),
    .swap_outbits (swap_outbits),
    .lane         (lane)
  );

endmodule

`default_nettype wire

//--- rtl/enc_8b10b.sv
// 8b10b encoder; k=1 always yields K28.y, other K characters are not supported
`timescale 1ns/1ps
`default_nettype none
`include "elink_config.svh"

module enc_8b10b
  import elink_pkg::*;
(
  input  wire                         bit_clk,
  input  wire                         arst_n,
  input  elink_sym_t                  sym,
  input  wire                         load,
  output logic [`ELINK_SYM_BITS-1:0]  enc  // lane order, bit 0 = 'a'
);

  logic       rd;      // 0 = RD-, 1 = RD+
  logic       rd_mid;  // disparity between the sub-blocks
  logic       rd_next;
  logic [4:0] x;       // EDCBA
  logic [2:0] y;       // HGF
  logic [5:0] six_p;   // RD- form
  logic [5:0] six;
  logic [3:0] four_p;
  logic [3:0] four;
  logic       unbal6;
  logic       unbal4;
  logic       use_a7;
  logic       flip4;
  logic [9:0] code;    // abcdei fghj, 'a' at msb

  always_comb begin
    x      = sym.data[4:0];
    y      = sym.data[7:5];
    six_p  = sym.k ? 6'b001111 : enc6_rdn(x); // K28 sub-block
    unbal6 = ($countones(six_p) != 3);
    // complement under RD+ when unbalanced, D.07 too
    six    = (rd && (unbal6 || (x == 5'd7 && !sym.k))) ? ~six_p : six_p;
    rd_mid = rd ^ unbal6;

    // alternate x.7 avoids a run of five
    use_a7 = !sym.k && (y == 3'd7) &&
             ((!rd_mid && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
              ( rd_mid && (x == 5'd11 || x == 5'd13 || x == 5'd14)));
    four_p = use_a7 ? 4'b0111 : enc4_rdn(y);
    unbal4 = ($countones(four_p) != 2);

    if (sym.k) begin
      flip4 = rd_mid ^ !unbal4; // K28 balanced codes invert when rd_mid is negative
    end else begin
      flip4 = rd_mid && (unbal4 || y == 3'd3);
    end
    four    = flip4 ? ~four_p : four_p;
    rd_next = rd_mid ^ unbal4;

    code = {six, four};
    for (int i = 0; i < `ELINK_SYM_BITS; i++) begin
      enc[i] = code[`ELINK_SYM_BITS-1-i]; // 'a' leaves first
    end
  end

  // running disparity, moves only when a symbol is taken
  always_ff @(posedge bit_clk or negedge arst_n) begin
    if (!arst_n) begin
      rd <= 1'b0;
    end else if (load) begin
      rd <= rd_next;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e

verilator --binary --timing --assert -f verilog.f --top-module elink_tb -o elink_sim
./obj_dir/elink_sim > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation clean"

//--- verilog.f
+incdir+rtl
rtl/elink_pkg.sv
rtl/elink_sym_if.sv
rtl/enc_8b10b.sv
rtl/dec_8b10b.sv
rtl/elink_serializer.sv
rtl/elink_tx.sv
rtl/elink_rx.sv
rtl/elink_loopback_top.sv
dv/elink_tb.sv
